// ==== common/ifu_defines.svh ====
//--------------------
// Global sizing for the instruction fetch unit
// Include wherever a bus or counter width is needed
//--------------------

`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// Memory side
`define IFU_AWIDTH  32      // Byte address width
`define IFU_DWIDTH  32      // Read data width

// Instruction queue
`define IFU_QHALF   4       // Depth in halfwords, two words

// Transaction bookkeeping
// Pending and discard counters share this width
// Max 7 transactions in flight
`define IFU_TXN_W   3

`endif

// ==== common/ifu_pkg.sv ====
//--------------------
// Shared types of the instruction fetch unit
// Memory read word views, response bundle, queue head and pop
// Import with a wildcard in the module header
//--------------------

`include "ifu_defines.svh"

package ifu_pkg;

    //--------------------
    // Memory read word
    //--------------------

    // Two halfwords of one read word
    typedef struct packed {
        logic [`IFU_DWIDTH/2-1:0] hi_half;  // Bits 31:16
        logic [`IFU_DWIDTH/2-1:0] lo_half;  // Bits 15:0
    } imem_half_t;

    // Same word seen whole or split
    typedef union packed {
        logic [`IFU_DWIDTH-1:0] word;
        imem_half_t             half;
    } imem_word_u;

    // Classified memory response
    typedef struct packed {
        logic       vd;     // Accepted, not discarded
        logic       er;     // Access fault
        logic       ok;     // Good data
        imem_word_u data;
    } imem_resp_t;

    //--------------------
    // Queue to decode side
    //--------------------

    typedef struct packed {
        logic                     empty;
        logic                     one_hw;     // Exactly one halfword held
        logic [`IFU_DWIDTH/2-1:0] head_data;
        logic [`IFU_DWIDTH/2-1:0] next_data;
        logic                     head_err;
        logic                     next_err;
    } q_head_t;

    // Pop request back to the queue
    typedef struct packed {
        logic pop;
        logic pop_hword;    // 1 halfword, else 2
    } q_pop_t;

    // Fetch FSM
    typedef enum logic {
        IDLE,
        FETCH
    } ifu_fsm_e;

endpackage

// ==== fetch/ifu_imem_ctrl.sv ====
//--------------------
// Memory side of the fetch unit
// Runs the fetch FSM, issues word reads, tracks pending and
// discarded transactions and flags which responses are kept
//--------------------

`include "ifu_defines.svh"

module ifu_imem_ctrl
    import ifu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stop_fetch_i,    // Level, stop fetching
    input  logic                   pc_new_req_i,    // Redirect strobe
    input  logic [`IFU_AWIDTH-1:0] pc_new_i,
    input  logic                   imem_ack_i,
    input  logic [`IFU_DWIDTH-1:0] imem_rdata_i,
    input  logic                   imem_resp_ok_i,
    input  logic                   imem_resp_er_i,
    input  logic [`IFU_TXN_W-1:0]  q_free_words_i,  // Whole free words in queue
    output logic                   imem_req_o,
    output logic [`IFU_AWIDTH-1:0] imem_addr_o,
    output imem_resp_t             resp_o
);

    // Handshake and response
    logic                     hs_done;
    logic                     resp_rcvd;
    logic                     discard_req;
    logic                     er_undisc;        // Fault that is not being dropped

    // FSM
    ifu_fsm_e                 fsm_ff;
    ifu_fsm_e                 fsm_next;
    logic                     fetch_req;
    logic                     stop_req;
    logic                     fsm_fetch;

    // Word address
    logic [`IFU_AWIDTH-1:2]   addr_ff;
    logic [`IFU_AWIDTH-1:2]   addr_next;

    // Counters
    logic [`IFU_TXN_W-1:0]    pnd_cnt;
    logic [`IFU_TXN_W-1:0]    pnd_cnt_next;
    logic [`IFU_TXN_W-1:0]    disc_cnt;
    logic [`IFU_TXN_W-1:0]    disc_cnt_next;
    logic                     disc_upd;
    logic [`IFU_TXN_W-1:0]    vd_pnd_cnt;       // Pending and still wanted
    logic                     pnd_full;
    logic                     has_free_slots;

    //--------------------
    // Response classification
    //--------------------

    assign hs_done     = imem_req_o & imem_ack_i;
    assign resp_rcvd   = imem_resp_ok_i | imem_resp_er_i;
    assign discard_req = |disc_cnt;
    assign er_undisc   = imem_resp_er_i & ~discard_req;

    assign resp_o.vd        = resp_rcvd & ~discard_req;
    assign resp_o.er        = imem_resp_er_i;
    assign resp_o.ok        = imem_resp_ok_i;
    assign resp_o.data.word = imem_rdata_i;

    //--------------------
    // Fetch FSM
    //--------------------

    assign fetch_req = pc_new_req_i & ~stop_fetch_i;
    assign stop_req  = stop_fetch_i | (er_undisc & ~pc_new_req_i);  // Fault parks the unit

    always_comb begin
        case (fsm_ff)
            IDLE:    fsm_next = fetch_req ? FETCH : IDLE;
            FETCH:   fsm_next = stop_req ? IDLE : FETCH;
            default: fsm_next = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            fsm_ff <= IDLE;
        end else begin
            fsm_ff <= fsm_next;
        end
    end

    assign fsm_fetch = (fsm_ff == FETCH);

    //--------------------
    // Address and counters
    //--------------------

    // Redirect restarts from new PC, otherwise step on each accepted read
    assign addr_next = pc_new_req_i ? pc_new_i[`IFU_AWIDTH-1:2] + (`IFU_AWIDTH-2)'(hs_done)
                                    : addr_ff + (`IFU_AWIDTH-2)'(hs_done);

    assign pnd_cnt_next = pnd_cnt + `IFU_TXN_W'(hs_done) - `IFU_TXN_W'(resp_rcvd);
    assign pnd_full     = &pnd_cnt;

    // Reload on redirect or kept fault, count down per dropped response
    assign disc_upd      = pc_new_req_i | imem_resp_er_i | (imem_resp_ok_i & discard_req);
    assign disc_cnt_next = pc_new_req_i ? pnd_cnt_next - `IFU_TXN_W'(hs_done)
                         : er_undisc    ? pnd_cnt_next
                                        : disc_cnt - 1'b1;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            addr_ff  <= '0;
            pnd_cnt  <= '0;
            disc_cnt <= '0;
        end else begin
            addr_ff <= addr_next;
            pnd_cnt <= pnd_cnt_next;
            if (disc_upd) begin
                disc_cnt <= disc_cnt_next;
            end
        end
    end

    assign vd_pnd_cnt     = pnd_cnt - disc_cnt;
    assign has_free_slots = (q_free_words_i > vd_pnd_cnt);  // Room for every kept reply

    //--------------------
    // Memory request
    //--------------------

    assign imem_req_o  = (pc_new_req_i & ~pnd_full & ~stop_fetch_i)
                       | (fsm_fetch & ~pnd_full & has_free_slots);
    assign imem_addr_o = pc_new_req_i ? {pc_new_i[`IFU_AWIDTH-1:2], 2'b00}
                                      : {addr_ff, 2'b00};

endmodule

// ==== queue/ifu_instr_queue.sv ====
//--------------------
// Instruction queue of the fetch unit
// Splits kept responses into halfwords and stores them
// for the decode side, four halfwords deep
//--------------------

`include "ifu_defines.svh"

module ifu_instr_queue
    import ifu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stop_fetch_i,
    input  logic                  pc_new_req_i,
    input  logic                  pc_new_bit1_i,   // New PC at odd halfword
    input  imem_resp_t            resp_i,
    input  q_pop_t                pop_i,
    output q_head_t               head_o,
    output logic [`IFU_TXN_W-1:0] q_free_words_o
);

    localparam int ADR_W = $clog2(`IFU_QHALF);
    localparam int PTR_W = ADR_W + 1;       // Extra wrap bit

    logic                     flush;

    // Unaligned start
    logic                     unalgn_ff;        // First word starts at upper half

    // Write control
    logic                     wr_en;
    logic                     wr_full;
    logic                     wr_hi;

    // Pointers
    logic [PTR_W-1:0]         wptr;
    logic [PTR_W-1:0]         wptr_next;
    logic [PTR_W-1:0]         rptr;
    logic [PTR_W-1:0]         rptr_next;
    logic [ADR_W-1:0]         wadr;
    logic [ADR_W-1:0]         wadr_nx;
    logic [ADR_W-1:0]         radr;
    logic [ADR_W-1:0]         radr_nx;
    logic [PTR_W-1:0]         ocpd;
    logic [PTR_W-1:0]         ocpd_next;
    logic [PTR_W-1:0]         free_h;

    // Halfword storage
    logic [`IFU_DWIDTH/2-1:0] q_data [`IFU_QHALF];
    logic                     q_err  [`IFU_QHALF];

    assign flush = pc_new_req_i | stop_fetch_i;

    //--------------------
    // Unaligned start
    //--------------------

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            unalgn_ff <= 1'b0;
        end else if (pc_new_req_i) begin
            unalgn_ff <= pc_new_bit1_i;
        end else if (resp_i.vd) begin
            unalgn_ff <= 1'b0;                   // Only the first word
        end
    end

    // Faults always write both halves
    assign wr_en   = resp_i.vd & ~flush;
    assign wr_full = wr_en & (resp_i.er | ~unalgn_ff);
    assign wr_hi   = wr_en & resp_i.ok & unalgn_ff;

    //--------------------
    // Pointers
    //--------------------

    assign wptr_next = flush   ? '0
                     : wr_full ? wptr + PTR_W'(2)
                     : wr_hi   ? wptr + PTR_W'(1)
                               : wptr;

    assign rptr_next = flush           ? '0
                     : ~pop_i.pop      ? rptr
                     : pop_i.pop_hword ? rptr + PTR_W'(1)
                                       : rptr + PTR_W'(2);

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            wptr <= wptr_next;
            rptr <= rptr_next;
        end
    end

    assign wadr    = wptr[ADR_W-1:0];
    assign wadr_nx = ADR_W'(wptr + 1'b1);
    assign radr    = rptr[ADR_W-1:0];
    assign radr_nx = ADR_W'(rptr + 1'b1);

    //--------------------
    // Storage
    //--------------------

    always_ff @(posedge clk) begin
        if (wr_full) begin
            q_data[wadr]    <= resp_i.data.half.lo_half;
            q_err[wadr]     <= resp_i.er;
            q_data[wadr_nx] <= resp_i.data.half.hi_half;
            q_err[wadr_nx]  <= resp_i.er;
        end else if (wr_hi) begin
            q_data[wadr]    <= resp_i.data.half.hi_half;  // Skip lower half
            q_err[wadr]     <= resp_i.er;
        end
    end

    // Head view
    assign ocpd             = wptr - rptr;
    assign head_o.empty     = (wptr == rptr);
    assign head_o.one_hw    = (ocpd == PTR_W'(1));
    assign head_o.head_data = q_data[radr];
    assign head_o.next_data = q_data[radr_nx];
    assign head_o.head_err  = q_err[radr];
    assign head_o.next_err  = q_err[radr_nx];

    // Free whole words after this cycle's pop
    assign ocpd_next      = wptr - rptr_next;
    assign free_h         = PTR_W'(`IFU_QHALF) - ocpd_next;
    assign q_free_words_o = `IFU_TXN_W'(free_h >> 1);

endmodule

// ==== design/ifu_idu_out.sv ====
//--------------------
// Decode side output of the fetch unit
// Builds one instruction from the queue head with its fault
// flags and asks the queue to pop it once consumed
//--------------------

`include "ifu_defines.svh"

module ifu_idu_out
    import ifu_pkg::*;
(
    input  q_head_t                head_i,
    input  logic                   idu_rdy_i,
    output logic [`IFU_DWIDTH-1:0] idu_instr_o,
    output logic                   idu_vd_o,
    output logic                   idu_err_o,
    output logic                   idu_err_rvi_hi_o,  // Fault on upper RVI half only
    output q_pop_t                 pop_o
);

    logic head_is_rvi;
    logic head_is_rvc;

    assign head_is_rvi = &head_i.head_data[1:0];
    assign head_is_rvc = ~head_is_rvi;

    //--------------------
    // Valid and faults
    //--------------------

    always_comb begin
        idu_vd_o         = 1'b0;
        idu_err_o        = 1'b0;
        idu_err_rvi_hi_o = 1'b0;
        if (~head_i.empty) begin
            if (head_i.one_hw) begin
                // RVI waits for its second half
                idu_vd_o  = head_is_rvc | head_i.head_err;
                idu_err_o = head_i.head_err;
            end else begin
                idu_vd_o         = 1'b1;
                idu_err_o        = head_i.head_err | (head_is_rvi & head_i.next_err);
                idu_err_rvi_hi_o = ~head_i.head_err & head_is_rvi & head_i.next_err;
            end
        end
    end

    // RVC is zero extended
    assign idu_instr_o = head_is_rvc ? `IFU_DWIDTH'(head_i.head_data)
                                     : {head_i.next_data, head_i.head_data};

    //--------------------
    // Pop
    //--------------------

    assign pop_o.pop       = idu_vd_o & idu_rdy_i;
    assign pop_o.pop_hword = head_is_rvc | head_i.head_err;  // Faulted head leaves alone

endmodule

// ==== design/ifu_top.sv ====
//--------------------
// Top level of the instruction fetch unit
// Memory controller and queue side by side, output selector
// combining them toward the decode stage
//--------------------

`include "ifu_defines.svh"

module ifu_top
    import ifu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stop_fetch_i,
    input  logic                   pc_new_req_i,
    input  logic [`IFU_AWIDTH-1:0] pc_new_i,
    input  logic                   imem_ack_i,
    input  logic [`IFU_DWIDTH-1:0] imem_rdata_i,
    input  logic                   imem_resp_ok_i,
    input  logic                   imem_resp_er_i,
    input  logic                   idu_rdy_i,
    output logic                   imem_req_o,
    output logic [`IFU_AWIDTH-1:0] imem_addr_o,
    output logic [`IFU_DWIDTH-1:0] idu_instr_o,
    output logic                   idu_vd_o,
    output logic                   idu_err_o,
    output logic                   idu_err_rvi_hi_o
);

    imem_resp_t            resp;
    q_head_t               head;
    q_pop_t                pop;
    logic [`IFU_TXN_W-1:0] q_free_words;

    ifu_imem_ctrl u_imem_ctrl (
        .clk, .rst_n, .stop_fetch_i, .pc_new_req_i, .pc_new_i,
        .imem_ack_i, .imem_rdata_i, .imem_resp_ok_i, .imem_resp_er_i,
        .q_free_words_i (q_free_words),
        .imem_req_o, .imem_addr_o,
        .resp_o         (resp)
    );

    ifu_instr_queue u_instr_queue (
        .clk, .rst_n, .stop_fetch_i, .pc_new_req_i,
        .pc_new_bit1_i  (pc_new_i[1]),
        .resp_i         (resp),
        .pop_i          (pop),
        .head_o         (head),
        .q_free_words_o (q_free_words)
    );

    ifu_idu_out u_idu_out (
        .head_i (head), .idu_rdy_i,
        .idu_instr_o, .idu_vd_o, .idu_err_o, .idu_err_rvi_hi_o,
        .pop_o  (pop)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
//--------------------
// Clock and reset source for the fetch unit testbench
// Free running clock, active low reset held for a set number of cycles
//--------------------

module tb_clk_gen #(
    parameter real PERIOD_NS  = 20.0,
    parameter int  RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                      // Release on an edge
    end

endmodule

// ==== bench/tb_ifu.sv ====
//--------------------
// Testbench of the instruction fetch unit
// Random memory image and latency, random decode stall,
// every consumed instruction checked against a reference stream
//--------------------

`include "ifu_defines.svh"

module tb_ifu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TEST_CYCLES = 1500;          // Rough length of all tests
    localparam int TIMEOUT_CYC = 4 * TEST_CYCLES;
    localparam int IMG_WORDS   = 64;
    localparam int FAULT_IDX   = 20;            // Word at 0x50

    typedef struct packed {
        logic [`IFU_DWIDTH-1:0] instr;
        logic [`IFU_AWIDTH-1:0] next_pc;
        logic                   err;
        logic                   err_hi;
    } exp_t;

    logic                   clk;
    logic                   rst_n;
    logic                   stop_fetch_i   = 1'b0;
    logic                   pc_new_req_i   = 1'b0;
    logic [`IFU_AWIDTH-1:0] pc_new_i       = '0;
    logic                   imem_ack_i     = 1'b0;
    logic [`IFU_DWIDTH-1:0] imem_rdata_i   = '0;
    logic                   imem_resp_ok_i = 1'b0;
    logic                   imem_resp_er_i = 1'b0;
    logic                   idu_rdy_i      = 1'b0;
    logic                   imem_req_o;
    logic [`IFU_AWIDTH-1:0] imem_addr_o;
    logic [`IFU_DWIDTH-1:0] idu_instr_o;
    logic                   idu_vd_o;
    logic                   idu_err_o;
    logic                   idu_err_rvi_hi_o;

    // Memory model state
    logic [`IFU_DWIDTH-1:0] img [IMG_WORDS];
    logic                   fault_map [IMG_WORDS];
    logic [`IFU_AWIDTH-1:0] rd_addr_q [$];      // Accepted reads, oldest first
    int                     rd_due_q [$];
    logic [`IFU_AWIDTH-1:0] next_addr;
    logic [`IFU_AWIDTH-1:0] base_addr;
    logic [`IFU_AWIDTH-1:0] rsp_addr;
    logic [`IFU_AWIDTH-1:0] redir_pc [3] = '{32'h0C8, 32'h036, 32'h0F0};

    int                     seed;
    int                     cyc        = 0;
    int                     inflight   = 0;
    int                     ack_thr    = 200;   // Out of 256
    int                     rdy_thr    = 200;
    int                     consumed   = 0;
    logic [`IFU_AWIDTH-1:0] exp_pc     = '0;
    logic                   stop_seen  = 1'b0;
    exp_t                   mon_exp;
    string                  test_name  = "reset";

    tb_clk_gen #(.PERIOD_NS(20.0), .RST_CYCLES(10)) u_clk_gen (.clk, .rst_n);

    ifu_top dut (.*);

    //--------------------
    // Reference and checks
    //--------------------

    function automatic logic [15:0] half_at(input logic [`IFU_AWIDTH-1:0] a);
        logic [`IFU_DWIDTH-1:0] w;
        w = img[a[7:2]];
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic exp_t expect_instr(input logic [`IFU_AWIDTH-1:0] pc);
        exp_t                   r;
        logic [`IFU_AWIDTH-1:0] pc2;
        logic [15:0]            hw0;
        pc2      = pc + 2;
        hw0      = half_at(pc);
        r.instr  = {16'h0000, hw0};             // RVC zero extended
        r.next_pc = pc2;
        r.err    = 1'b0;
        r.err_hi = 1'b0;
        if (fault_map[pc[7:2]]) begin
            r.err = 1'b1;                       // Faulted halfword leaves alone
        end else if (hw0[1:0] == 2'b11) begin
            r.instr   = {half_at(pc2), hw0};
            r.next_pc = pc + 4;
            r.err     = fault_map[pc2[7:2]];
            r.err_hi  = fault_map[pc2[7:2]];    // Only the upper half hit
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_instr(input string name, input logic [`IFU_DWIDTH-1:0] exp_v,
                               input logic [`IFU_DWIDTH-1:0] act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    task automatic check_flags(input string name, input logic [1:0] exp_v,
                               input logic [1:0] act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp_v, act_v));
        end
    endtask

    task automatic check_addr(input string name, input logic [`IFU_AWIDTH-1:0] exp_v,
                              input logic [`IFU_AWIDTH-1:0] act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    //--------------------
    // Memory, decode and timeout models
    //--------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            next_addr = '0;
        end else begin
            base_addr = pc_new_req_i ? {pc_new_i[`IFU_AWIDTH-1:2], 2'b00} : next_addr;
            next_addr = base_addr;
            if (imem_req_o && imem_ack_i) begin
                check_addr({test_name, " req addr"}, base_addr, imem_addr_o);
                rd_addr_q.push_back(imem_addr_o);
                rd_due_q.push_back(cyc + $unsigned($random(seed)) % 3);  // 1 to 3 cycles
                next_addr = base_addr + 4;
            end
            imem_resp_ok_i <= 1'b0;
            imem_resp_er_i <= 1'b0;
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
                rsp_addr = rd_addr_q.pop_front();
                void'(rd_due_q.pop_front());
                imem_rdata_i <= img[rsp_addr[7:2]];
                if (fault_map[rsp_addr[7:2]]) imem_resp_er_i <= 1'b1;
                else                          imem_resp_ok_i <= 1'b1;
            end
            imem_ack_i <= ($unsigned($random(seed)) % 256) < ack_thr;
            inflight   <= rd_addr_q.size();
        end
    end

    always @(posedge clk) begin
        if (rst_n) idu_rdy_i <= ($unsigned($random(seed)) % 256) < rdy_thr;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            abort_run($sformatf("Timeout after %0d cycles, fetch stream stalled", cyc));
        end
    end

    //--------------------
    // Compare process
    //--------------------

    always @(posedge clk) begin
        if (rst_n) begin
            if (idu_vd_o && idu_rdy_i) begin
                mon_exp = expect_instr(exp_pc);
                check_flags($sformatf("%s flags at %h", test_name, exp_pc),
                            {mon_exp.err, mon_exp.err_hi}, {idu_err_o, idu_err_rvi_hi_o});
                if (!mon_exp.err) begin     // Faulted word carries no usable data
                    check_instr($sformatf("%s instr at %h", test_name, exp_pc),
                                mon_exp.instr, idu_instr_o);
                end
                consumed <= consumed + 1;
                exp_pc   <= mon_exp.next_pc;
            end
            if (pc_new_req_i) exp_pc <= pc_new_i;   // Overrides the step above
            if (stop_fetch_i) begin
                if (stop_seen && imem_req_o && imem_ack_i) begin
                    abort_run("Memory request accepted after stop fetch took effect");
                end
                if (stop_seen && idu_vd_o) begin
                    abort_run("Valid instruction while stop fetch is held");
                end
                stop_seen <= 1'b1;
            end else begin
                stop_seen <= 1'b0;
            end
        end
    end

    //--------------------
    // Tests
    //--------------------

    task automatic new_pc(input logic [`IFU_AWIDTH-1:0] pc);
        @(posedge clk);
        pc_new_req_i <= 1'b1;
        pc_new_i     <= pc;
        @(posedge clk);
        pc_new_req_i <= 1'b0;
    endtask

    task automatic wait_consumed(input int n);
        int target;
        target = consumed + n;
        while (consumed < target) @(posedge clk);
    endtask

    initial begin
        seed = 14;
        for (int i = 0; i < IMG_WORDS; i++) begin
            img[i]       = $random(seed);       // Random RVC and RVI mix
            fault_map[i] = 1'b0;
        end
        wait (rst_n);
        @(posedge clk);

        test_name = "aligned";
        rdy_thr   = 256;                        // Decode always ready
        new_pc(32'h000);
        wait_consumed(40);

        test_name = "unaligned";
        rdy_thr   = 200;
        new_pc(32'h0A2);
        wait_consumed(20);

        test_name = "redirect";
        for (int i = 0; i < 3; i++) begin
            wait_consumed(5);
            while (inflight == 0) @(posedge clk);
            new_pc(redir_pc[i]);
            wait_consumed(15);
        end

        test_name = "backpressure";
        rdy_thr   = 100;
        ack_thr   = 128;
        new_pc(32'h010);
        wait_consumed(60);

        test_name = "fault";
        rdy_thr   = 200;
        ack_thr   = 200;
        new_pc(32'h030);
        @(posedge clk);                         // Old stream flushed by now
        fault_map[FAULT_IDX] = 1'b1;
        while (exp_pc[`IFU_AWIDTH-1:2] <= FAULT_IDX) @(posedge clk);
        repeat (30) begin
            @(posedge clk);
            if (idu_vd_o) abort_run("Valid instruction after an access fault without new PC");
        end
        fault_map[FAULT_IDX] = 1'b0;

        test_name = "stop";
        new_pc(32'h080);
        wait_consumed(10);
        @(posedge clk);
        stop_fetch_i <= 1'b1;
        repeat (16) @(posedge clk);             // Long enough to drain replies
        stop_fetch_i <= 1'b0;
        new_pc(32'h006);
        wait_consumed(10);

        repeat (5) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+common
common/ifu_pkg.sv
fetch/ifu_imem_ctrl.sv
queue/ifu_instr_queue.sv
design/ifu_idu_out.sv
design/ifu_top.sv
bench/tb_clk_gen.sv
bench/tb_ifu.sv

// ==== Bender.yml ====
package:
  name: ifu_fetch

sources:
  - include_dirs:
      - common
    files:
      - common/ifu_pkg.sv
      - fetch/ifu_imem_ctrl.sv
      - queue/ifu_instr_queue.sv
      - design/ifu_idu_out.sv
      - design/ifu_top.sv
      - target: test
        files:
          - bench/tb_clk_gen.sv
          - bench/tb_ifu.sv
